// File: design/burst_pkg.sv
package burst_pkg;

	localparam int NUM_SLOTS = 4;             // burst slots in the pool
	localparam int SLOT_W    = 2;             // slot index
	localparam int BURST_LEN = 16;            // beats per burst
	localparam int BEAT_W    = 4;             // beat index
	localparam int DATA_W    = 16;            // one DQ beat
	localparam int TAG_W     = 4;             // requester tag
	localparam int COLGRP_W  = 6;             // column bits above the beat index
	localparam int BG_W      = 2;
	localparam int BANK_W    = 2;
	localparam int ROW_W     = 16;
	localparam int COL_W     = COLGRP_W + BEAT_W;

	typedef enum logic [1:0] {
		SLOT_EMPTY,                           // free for a new burst
		SLOT_FILLING,                         // still taking requests
		SLOT_FULL,                            // closed, waiting for commands
		SLOT_RETURNING                        // data phase started, beats going back
	} slot_state_e;

	typedef enum logic {
		REQ_READ,
		REQ_WRITE
	} req_kind_e;

	typedef struct packed {
		logic [BG_W-1:0]   bank_group;
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0]  row;
		logic [COL_W-1:0]  column;            // low BEAT_W bits pick the beat
	} req_addr_t;

	typedef struct packed {
		logic [BG_W-1:0]     bank_group;
		logic [BANK_W-1:0]   bank;
		logic [ROW_W-1:0]    row;
		logic [COLGRP_W-1:0] colgrp;
	} burst_addr_t;

endpackage

// File: design/ddr5_pkg.sv
package ddr5_pkg;

	localparam int CA_W       = 14;           // command/address pins
	localparam int DM_W       = 3;            // data mask pins
	localparam int RD_TO_DATA = 11;           // phase 1 to first read beat
	localparam int WR_TO_DATA = 8;            // phase 1 to first write beat
	localparam int WAIT_W     = $clog2(RD_TO_DATA);

	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_ACT,                              // two phases
		CMD_RD,                               // two phases
		CMD_WR,                               // two phases
		CMD_PRE,                              // single phase
		CMD_REFAB                             // single phase
	} ddr5_cmd_e;

	// opcode fields at the bottom of phase 1
	localparam logic [4:0]      OP_RD    = 5'b11101;
	localparam logic [4:0]      OP_WR    = 5'b01101;
	localparam logic [5:0]      OP_PRE   = 6'b011011;
	localparam logic [CA_W-1:0] OP_REFAB = 14'h13;  // whole word, no address

	localparam logic BL_BAR = 1'b1;           // burst length 16
	localparam logic AP_BAR = 1'b1;           // no auto precharge

endpackage

// File: design/burst_if.sv
`timescale 1ns/10ps

// request collector into the slot store
interface fill_if;
	import burst_pkg::*;

	logic                 fill;               // write one beat into fill_slot
	logic                 open_new;           // start a fresh burst there
	logic                 close;
	logic [SLOT_W-1:0]    fill_slot;
	logic [SLOT_W-1:0]    close_slot;
	logic [BEAT_W-1:0]    beat;
	req_kind_e            kind;
	burst_addr_t          addr;
	logic [DATA_W-1:0]    data;
	logic [TAG_W-1:0]     tag;
	slot_state_e          state [NUM_SLOTS];
	req_kind_e            kind_of [NUM_SLOTS];
	burst_addr_t          addr_of [NUM_SLOTS];

	modport collector (
		output fill, open_new, close, fill_slot, close_slot, beat, kind, addr, data, tag,
		input  state, kind_of, addr_of
	);
	modport store (
		input  fill, open_new, close, fill_slot, close_slot, beat, kind, addr, data, tag,
		output state, kind_of, addr_of
	);
endinterface

// command engine against the slot store
interface mem_if;
	import burst_pkg::*;

	logic                 cap;                // read beat from dq_in
	logic [SLOT_W-1:0]    cap_slot;
	logic [BEAT_W-1:0]    cap_beat;
	logic [DATA_W-1:0]    cap_data;
	logic                 go_return;          // first beat of the data phase
	logic [SLOT_W-1:0]    go_slot;
	logic [SLOT_W-1:0]    rd_slot;
	logic [BEAT_W-1:0]    rd_beat;
	logic [BEAT_W:0]      beats_done [NUM_SLOTS];  // 0 to 16
	logic [DATA_W-1:0]    rd_data;
	logic                 rd_mask_bit;
	logic [BURST_LEN-1:0] rd_full_mask;
	burst_addr_t          rd_addr;

	modport engine (
		output cap, cap_slot, cap_beat, cap_data, go_return, go_slot, rd_slot, rd_beat,
		output beats_done,
		input  rd_data, rd_mask_bit, rd_full_mask, rd_addr
	);
	modport store (
		input  cap, cap_slot, cap_beat, cap_data, go_return, go_slot, rd_slot, rd_beat,
		output rd_data, rd_mask_bit, rd_full_mask, rd_addr
	);
	modport monitor (input beats_done);
endinterface

// returner against the slot store
interface ret_if;
	import burst_pkg::*;

	logic                 pop;                // beat sent, drop its mask bit
	logic [SLOT_W-1:0]    pop_slot;           // also the slot to release
	logic [BEAT_W-1:0]    pop_beat;
	logic                 slot_release;
	slot_state_e          state [NUM_SLOTS];
	logic [BURST_LEN-1:0] mask [NUM_SLOTS];
	logic [BURST_LEN-1:0][DATA_W-1:0] data [NUM_SLOTS];
	logic [BURST_LEN-1:0][TAG_W-1:0]  tags [NUM_SLOTS];
	req_kind_e            kind [NUM_SLOTS];

	modport returner (
		output pop, pop_slot, pop_beat, slot_release,
		input  state, mask, data, tags, kind
	);
	modport store (
		input  pop, pop_slot, pop_beat, slot_release,
		output state, mask, data, tags, kind
	);
endinterface

// File: design/burst_slots.sv
`timescale 1ns/10ps

module burst_slots (
	input  logic clk,
	input  logic rst_n,
	fill_if.store fill,
	mem_if.store  mem,
	ret_if.store  ret,
	output burst_pkg::slot_state_e [burst_pkg::NUM_SLOTS-1:0] slot_state,
	output burst_pkg::req_kind_e   [burst_pkg::NUM_SLOTS-1:0] slot_kind,
	output logic [burst_pkg::NUM_SLOTS-1:0][burst_pkg::BANK_W-1:0] slot_bank,
	output logic [burst_pkg::NUM_SLOTS-1:0][burst_pkg::BG_W-1:0]   slot_bg,
	output logic [burst_pkg::NUM_SLOTS-1:0][burst_pkg::ROW_W-1:0]  slot_row
);
	import burst_pkg::*;

	slot_state_e          st_q [NUM_SLOTS];
	req_kind_e            kind_q [NUM_SLOTS];
	burst_addr_t          addr_q [NUM_SLOTS];
	logic [BURST_LEN-1:0] mask_q [NUM_SLOTS];   // beats somebody asked for
	logic [BURST_LEN-1:0][DATA_W-1:0] data_q [NUM_SLOTS];
	logic [BURST_LEN-1:0][TAG_W-1:0]  tag_q [NUM_SLOTS];

	// later lines win when two sources hit the same slot
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				st_q[i]   <= SLOT_EMPTY;
				mask_q[i] <= '0;
			end
		end else begin
			if (fill.fill) begin
				if (fill.open_new) begin
					st_q[fill.fill_slot]   <= SLOT_FILLING;
					addr_q[fill.fill_slot] <= fill.addr;
					kind_q[fill.fill_slot] <= fill.kind;
					mask_q[fill.fill_slot] <= BURST_LEN'(1) << fill.beat;  // old beats dropped
				end else begin
					mask_q[fill.fill_slot][fill.beat] <= 1'b1;             // merge
				end
				tag_q[fill.fill_slot][fill.beat] <= fill.tag;
				if (fill.kind == REQ_WRITE)
					data_q[fill.fill_slot][fill.beat] <= fill.data;
			end
			if (fill.close && st_q[fill.close_slot] == SLOT_FILLING)
				st_q[fill.close_slot] <= SLOT_FULL;

			// read data only lands on requested beats
			if (mem.cap && mask_q[mem.cap_slot][mem.cap_beat])
				data_q[mem.cap_slot][mem.cap_beat] <= mem.cap_data;
			if (mem.go_return)
				st_q[mem.go_slot] <= SLOT_RETURNING;

			if (ret.pop)
				mask_q[ret.pop_slot][ret.pop_beat] <= 1'b0;
			if (ret.slot_release)
				st_q[ret.pop_slot] <= SLOT_EMPTY;     // burst fully returned
		end
	end

	assign fill.state   = st_q;
	assign fill.kind_of = kind_q;
	assign fill.addr_of = addr_q;

	// engine side, async read of one slot
	assign mem.rd_data      = data_q[mem.rd_slot][mem.rd_beat];
	assign mem.rd_mask_bit  = mask_q[mem.rd_slot][mem.rd_beat];
	assign mem.rd_full_mask = mask_q[mem.rd_slot];
	assign mem.rd_addr      = addr_q[mem.rd_slot];

	assign ret.state = st_q;
	assign ret.mask  = mask_q;
	assign ret.data  = data_q;
	assign ret.tags  = tag_q;
	assign ret.kind  = kind_q;

	// status toward the timing controller
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			slot_state[i] = st_q[i];
			slot_kind[i]  = kind_q[i];
			slot_bank[i]  = addr_q[i].bank;
			slot_bg[i]    = addr_q[i].bank_group;
			slot_row[i]   = addr_q[i].row;
		end
	end

endmodule

// File: design/burst_collector.sv
`timescale 1ns/10ps

module burst_collector (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid,
	input  logic req_write,
	input  burst_pkg::req_addr_t req_addr,
	input  logic [burst_pkg::DATA_W-1:0] req_data,
	input  logic [burst_pkg::TAG_W-1:0]  req_tag,
	output logic slot_ready,
	fill_if.collector fill
);
	import burst_pkg::*;

	logic [SLOT_W-1:0] last_slot;           // slot written by the previous request
	logic [SLOT_W-1:0] free_slot;           // lowest EMPTY one
	logic [SLOT_W:0]   empty_cnt;
	logic              merge;
	req_kind_e         req_kind;
	burst_addr_t       req_baddr;

	assign req_kind  = req_write ? REQ_WRITE : REQ_READ;
	assign req_baddr = '{bank_group: req_addr.bank_group,
	                     bank:       req_addr.bank,
	                     row:        req_addr.row,
	                     colgrp:     req_addr.column[COL_W-1:BEAT_W]};

	// same open burst, same address group, same direction
	assign merge = fill.state[last_slot] == SLOT_FILLING &&
	               fill.addr_of[last_slot] == req_baddr &&
	               fill.kind_of[last_slot] == req_kind;

	always_comb begin
		free_slot = '0;
		empty_cnt = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin  // downward so lowest wins
			if (fill.state[i] == SLOT_EMPTY) begin
				free_slot = SLOT_W'(i);
				empty_cnt = empty_cnt + 1'b1;
			end
		end
	end

	assign fill.fill       = req_valid;
	assign fill.open_new   = req_valid && !merge;
	assign fill.fill_slot  = merge ? last_slot : free_slot;
	assign fill.close      = fill.state[last_slot] == SLOT_FILLING && !(req_valid && merge);
	assign fill.close_slot = last_slot;
	assign fill.beat       = req_addr.column[BEAT_W-1:0];
	assign fill.kind       = req_kind;
	assign fill.addr       = req_baddr;
	assign fill.data       = req_data;
	assign fill.tag        = req_tag;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			last_slot  <= '0;
			slot_ready <= 1'b0;
		end else begin
			if (req_valid)
				last_slot <= fill.fill_slot;
			// keep one slot spare while a request may still open one
			slot_ready <= (empty_cnt > 1) || (empty_cnt == 1 && !req_valid);
		end
	end

endmodule

// File: design/ddr5_cmd_engine.sv
`timescale 1ns/10ps

module ddr5_cmd_engine (
	input  logic clk,
	input  logic rst_n,
	input  ddr5_pkg::ddr5_cmd_e cmd,
	input  logic [burst_pkg::SLOT_W-1:0] cmd_slot,
	output logic cs_n,
	output logic [ddr5_pkg::CA_W-1:0] ca,
	output logic [ddr5_pkg::DM_W-1:0] dm_n,
	output logic [burst_pkg::DATA_W-1:0] dq_out,
	output logic dq_oe,
	input  logic [burst_pkg::DATA_W-1:0] dq_in,
	mem_if.engine mem
);
	import burst_pkg::*;
	import ddr5_pkg::*;

	typedef enum logic [1:0] {
		DP_IDLE,
		DP_WAIT,                          // counting down to the first beat
		DP_DATA                           // beats 1 to 15
	} dp_state_e;

	dp_state_e         dp_q;
	ddr5_cmd_e         cmd_q;             // held for phase 2
	burst_addr_t       addr_q;
	burst_addr_t       cmd_addr;
	logic              full_q;            // every beat of the write is valid
	logic              p2_q;              // phase 2 due next edge
	logic              dwrite_q;
	logic              active;            // a data beat happens at this edge
	logic [SLOT_W-1:0] dslot_q;
	logic [BEAT_W-1:0] beat_q;
	logic [WAIT_W-1:0] wait_q;
	logic [CA_W-1:0]   ca_p1;
	logic [CA_W-1:0]   ca_p2;

	assign cmd_addr = mem.rd_addr;

	always_comb begin
		case (cmd)
			CMD_ACT:   ca_p1 = CA_W'({3'b000, cmd_addr.bank_group, cmd_addr.bank,
			                          cmd_addr.row[3:0], 2'b00});
			CMD_RD:    ca_p1 = CA_W'({3'b000, cmd_addr.bank_group, cmd_addr.bank, BL_BAR, OP_RD});
			CMD_WR:    ca_p1 = CA_W'({3'b000, cmd_addr.bank_group, cmd_addr.bank, BL_BAR, OP_WR});
			CMD_PRE:   ca_p1 = CA_W'({3'b000, cmd_addr.bank_group, cmd_addr.bank, OP_PRE});
			CMD_REFAB: ca_p1 = OP_REFAB;
			default:   ca_p1 = '0;
		endcase
	end

	always_comb begin
		case (cmd_q)
			CMD_ACT: ca_p2 = CA_W'(addr_q.row[ROW_W-1:4]);   // upper row bits
			CMD_RD:  ca_p2 = CA_W'({3'b000, AP_BAR, 1'b0, addr_q.colgrp, 1'b0, 1'b1});
			CMD_WR:  ca_p2 = CA_W'({2'b00, full_q, AP_BAR, 1'b0, addr_q.colgrp, 1'b0});
			default: ca_p2 = '0;
		endcase
	end

	assign active = (dp_q == DP_WAIT && wait_q == '0) || dp_q == DP_DATA;

	// command cycle needs the new slot address, otherwise the data slot
	assign mem.rd_slot   = (cmd != CMD_NONE) ? cmd_slot : dslot_q;
	assign mem.rd_beat   = beat_q;
	assign mem.cap       = active && !dwrite_q;
	assign mem.cap_slot  = dslot_q;
	assign mem.cap_beat  = beat_q;
	assign mem.cap_data  = dq_in;
	assign mem.go_return = active && beat_q == '0;
	assign mem.go_slot   = dslot_q;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			cs_n   <= 1'b1;
			ca     <= '0;
			p2_q   <= 1'b0;
			dp_q   <= DP_IDLE;
			beat_q <= '0;
			dq_oe  <= 1'b0;
			dm_n   <= '1;
			for (int i = 0; i < NUM_SLOTS; i++)
				mem.beats_done[i] <= '0;
		end else begin
			if (cmd != CMD_NONE) begin
				cs_n   <= 1'b0;
				ca     <= ca_p1;
				p2_q   <= cmd inside {CMD_ACT, CMD_RD, CMD_WR};
				cmd_q  <= cmd;
				addr_q <= cmd_addr;
				full_q <= &mem.rd_full_mask;
			end else if (p2_q) begin
				cs_n <= 1'b0;
				ca   <= ca_p2;
				p2_q <= 1'b0;
			end else begin
				cs_n <= 1'b1;                         // bus idle
				ca   <= '0;
			end

			dq_oe <= active && dwrite_q;
			dm_n  <= (active && dwrite_q && mem.rd_mask_bit) ? '0 : '1;
			if (active) begin
				mem.beats_done[dslot_q] <= {1'b0, beat_q} + 1'b1;
				beat_q <= beat_q + 1'b1;
				dp_q   <= (beat_q == BEAT_W'(BURST_LEN - 1)) ? DP_IDLE : DP_DATA;
			end else if (dp_q == DP_WAIT) begin
				wait_q <= wait_q - 1'b1;
			end

			if (cmd == CMD_RD || cmd == CMD_WR) begin  // arm the data phase
				dp_q     <= DP_WAIT;
				wait_q   <= (cmd == CMD_RD) ? WAIT_W'(RD_TO_DATA - 1) : WAIT_W'(WR_TO_DATA - 1);
				dslot_q  <= cmd_slot;
				dwrite_q <= cmd == CMD_WR;
				beat_q   <= '0;
				mem.beats_done[cmd_slot] <= '0;
			end
		end
	end

	// unrequested write beats go out as zero
	always_ff @(posedge clk)
		dq_out <= (active && dwrite_q && mem.rd_mask_bit) ? mem.rd_data : '0;

endmodule

// File: design/burst_returner.sv
`timescale 1ns/10ps

module burst_returner (
	input  logic clk,
	input  logic rst_n,
	ret_if.returner ret,
	output logic ret_valid,
	output logic ret_write,
	output logic [burst_pkg::DATA_W-1:0] ret_data,
	output logic [burst_pkg::TAG_W-1:0]  ret_tag,
	mem_if.monitor beats_done
);
	import burst_pkg::*;

	logic                 busy_q;         // a slot is being drained
	logic [SLOT_W-1:0]    cur_q;
	logic [SLOT_W-1:0]    pick;
	logic                 pick_ok;
	logic [BURST_LEN-1:0] mask;
	logic [BURST_LEN-1:0] low_bit;        // lowest pending beat, one hot
	logic [BEAT_W-1:0]    low_idx;

	always_comb begin
		pick    = '0;
		pick_ok = 1'b0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
			if (ret.state[i] == SLOT_RETURNING) begin
				pick    = SLOT_W'(i);
				pick_ok = 1'b1;
			end
		end
	end

	assign mask    = ret.mask[cur_q];
	assign low_bit = mask & (~mask + 1'b1);

	always_comb begin
		low_idx = '0;
		for (int i = 0; i < BURST_LEN; i++)
			if (low_bit[i])
				low_idx = BEAT_W'(i);
	end

	// beat goes out only once memory has moved past it
	assign ret.pop          = busy_q && mask != '0 &&
	                          beats_done.beats_done[cur_q] > {1'b0, low_idx};
	assign ret.pop_slot     = cur_q;
	assign ret.pop_beat     = low_idx;
	assign ret.slot_release = busy_q && mask == '0;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			busy_q    <= 1'b0;
			cur_q     <= '0;
			ret_valid <= 1'b0;
		end else begin
			ret_valid <= ret.pop;
			if (!busy_q && pick_ok) begin
				busy_q <= 1'b1;
				cur_q  <= pick;
			end else if (ret.slot_release) begin
				busy_q <= 1'b0;                   // free to pick the next one
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ret.pop) begin
			ret_data  <= ret.data[cur_q][low_idx];
			ret_tag   <= ret.tags[cur_q][low_idx];
			ret_write <= ret.kind[cur_q] == REQ_WRITE;
		end
	end

endmodule

// File: design/burst_handler.sv
`timescale 1ns/10ps

module burst_handler (
	input  logic clk,
	input  logic rst_n,
	// request side
	input  logic req_valid,
	input  logic req_write,
	input  burst_pkg::req_addr_t req_addr,
	input  logic [burst_pkg::DATA_W-1:0] req_data,
	input  logic [burst_pkg::TAG_W-1:0]  req_tag,
	output logic slot_ready,
	// timing controller
	output burst_pkg::slot_state_e [burst_pkg::NUM_SLOTS-1:0] slot_state,
	output burst_pkg::req_kind_e   [burst_pkg::NUM_SLOTS-1:0] slot_kind,
	output logic [burst_pkg::NUM_SLOTS-1:0][burst_pkg::BANK_W-1:0] slot_bank,
	output logic [burst_pkg::NUM_SLOTS-1:0][burst_pkg::BG_W-1:0]   slot_bg,
	output logic [burst_pkg::NUM_SLOTS-1:0][burst_pkg::ROW_W-1:0]  slot_row,
	input  ddr5_pkg::ddr5_cmd_e cmd,
	input  logic [burst_pkg::SLOT_W-1:0] cmd_slot,
	// DDR5 pins
	output logic cs_n,
	output logic [ddr5_pkg::CA_W-1:0] ca,
	output logic [ddr5_pkg::DM_W-1:0] dm_n,
	output logic [burst_pkg::DATA_W-1:0] dq_out,
	output logic dq_oe,
	input  logic [burst_pkg::DATA_W-1:0] dq_in,
	// returned beats
	output logic ret_valid,
	output logic ret_write,
	output logic [burst_pkg::DATA_W-1:0] ret_data,
	output logic [burst_pkg::TAG_W-1:0]  ret_tag
);

	fill_if fill_bus ();
	mem_if  mem_bus ();
	ret_if  ret_bus ();

	burst_slots i_slots (
		.clk        (clk),
		.rst_n      (rst_n),
		.fill       (fill_bus.store),
		.mem        (mem_bus.store),
		.ret        (ret_bus.store),
		.slot_state (slot_state),
		.slot_kind  (slot_kind),
		.slot_bank  (slot_bank),
		.slot_bg    (slot_bg),
		.slot_row   (slot_row)
	);

	burst_collector i_collector (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_write  (req_write),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.req_tag    (req_tag),
		.slot_ready (slot_ready),
		.fill       (fill_bus.collector)
	);

	ddr5_cmd_engine i_engine (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd      (cmd),
		.cmd_slot (cmd_slot),
		.cs_n     (cs_n),
		.ca       (ca),
		.dm_n     (dm_n),
		.dq_out   (dq_out),
		.dq_oe    (dq_oe),
		.dq_in    (dq_in),
		.mem      (mem_bus.engine)
	);

	burst_returner i_returner (
		.clk        (clk),
		.rst_n      (rst_n),
		.ret        (ret_bus.returner),
		.ret_valid  (ret_valid),
		.ret_write  (ret_write),
		.ret_data   (ret_data),
		.ret_tag    (ret_tag),
		.beats_done (mem_bus.monitor)
	);

endmodule

// File: verif/tb_burst_handler.sv
`timescale 1ns/10ps

module tb_burst_handler;
	import burst_pkg::*;
	import ddr5_pkg::*;

	localparam int NUM_ROUNDS = 20;
	localparam int NUM_TESTS  = 2 * NUM_ROUNDS + 9;  // bursts run, each well under 60 cycles

	logic clk = 1'b0;
	logic rst_n, req_valid, req_write, slot_ready;
	req_addr_t req_addr;
	logic [DATA_W-1:0] req_data, dq_out, dq_in, ret_data;
	logic [TAG_W-1:0] req_tag, ret_tag;
	slot_state_e [NUM_SLOTS-1:0] slot_state;
	req_kind_e [NUM_SLOTS-1:0] slot_kind;
	logic [NUM_SLOTS-1:0][BANK_W-1:0] slot_bank;
	logic [NUM_SLOTS-1:0][BG_W-1:0] slot_bg;
	logic [NUM_SLOTS-1:0][ROW_W-1:0] slot_row;
	ddr5_cmd_e cmd;
	logic [SLOT_W-1:0] cmd_slot;
	logic cs_n, dq_oe, ret_valid, ret_write;
	logic [CA_W-1:0] ca;
	logic [DM_W-1:0] dm_n;

	slot_state_e m_state [NUM_SLOTS];        // model of the slot pool
	req_kind_e m_kind [NUM_SLOTS];
	burst_addr_t m_addr [NUM_SLOTS];
	logic [BURST_LEN-1:0] m_mask [NUM_SLOTS];
	logic [DATA_W-1:0] m_data [NUM_SLOTS][BURST_LEN];
	logic [TAG_W-1:0] m_tag [NUM_SLOTS][BURST_LEN];
	int m_last = 0;                           // slot of the previous request
	logic [DATA_W+TAG_W:0] exp_q [$];         // {write, data, tag} in return order
	int value_errs = 0;
	int other_errs = 0;
	logic [31:0] rng = 32'h1223_9c99;

	burst_handler i_dut (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// CA word per phase, field order top to bottom
	function automatic logic [CA_W-1:0] expected_ca(ddr5_cmd_e c, burst_addr_t a, logic full,
	                                                logic second);
		logic [CA_W-1:0] w;
		w = '0;
		case (c)
			CMD_ACT: w = second ? CA_W'(a.row[15:4])
			                    : CA_W'({3'b000, a.bank_group, a.bank, a.row[3:0], 2'b00});
			CMD_RD:  w = second ? CA_W'({3'b000, AP_BAR, 1'b0, a.colgrp, 1'b0, 1'b1})
			                    : CA_W'({3'b000, a.bank_group, a.bank, BL_BAR, OP_RD});
			CMD_WR:  w = second ? CA_W'({2'b00, full, AP_BAR, 1'b0, a.colgrp, 1'b0})
			                    : CA_W'({3'b000, a.bank_group, a.bank, BL_BAR, OP_WR});
			CMD_PRE: w = second ? '0 : CA_W'({3'b000, a.bank_group, a.bank, OP_PRE});
			CMD_REFAB: w = second ? '0 : OP_REFAB;
			default: w = '0;
		endcase
		return w;
	endfunction

	task automatic model_request(logic w, req_addr_t a, logic [DATA_W-1:0] d,
	                             logic [TAG_W-1:0] t);
		burst_addr_t g;
		req_kind_e k;
		int s;
		g = '{bank_group: a.bank_group, bank: a.bank, row: a.row,
		      colgrp: a.column[COL_W-1:BEAT_W]};
		k = w ? REQ_WRITE : REQ_READ;
		s = m_last;
		if (!(m_state[s] == SLOT_FILLING && m_addr[s] == g && m_kind[s] == k)) begin
			if (m_state[m_last] == SLOT_FILLING)
				m_state[m_last] = SLOT_FULL;      // new group closes the old one
			for (int i = NUM_SLOTS - 1; i >= 0; i--)
				if (m_state[i] == SLOT_EMPTY)
					s = i;
			m_state[s] = SLOT_FILLING;
			m_addr[s]  = g;
			m_kind[s]  = k;
			m_mask[s]  = '0;
		end
		m_mask[s][a.column[BEAT_W-1:0]] = 1'b1;
		m_tag[s][a.column[BEAT_W-1:0]]  = t;
		if (w)
			m_data[s][a.column[BEAT_W-1:0]] = d;
		m_last = s;
	endtask

	task automatic check_slots(logic exp_ready);
		for (int i = 0; i < NUM_SLOTS; i++) begin
			assert (slot_state[i] == m_state[i]) else begin
				$display("ERROR %0t: slot %0d state %0d, expected %s", $time, i,
				         slot_state[i], m_state[i].name());
				value_errs++;
			end
			if (m_state[i] != SLOT_EMPTY)
				assert (slot_row[i] == m_addr[i].row && slot_bank[i] == m_addr[i].bank &&
				        slot_bg[i] == m_addr[i].bank_group && slot_kind[i] == m_kind[i]) else begin
					$display("ERROR %0t: slot %0d address or kind differs", $time, i);
					value_errs++;
				end
		end
		assert (slot_ready == exp_ready) else begin
			$display("ERROR %0t: slot_ready %b, expected %b", $time, slot_ready, exp_ready);
			value_errs++;
		end
	endtask

	task automatic send_req(logic w, req_addr_t a, logic [DATA_W-1:0] d, logic [TAG_W-1:0] t);
		@(negedge clk);
		while (!slot_ready)
			@(negedge clk);
		@(posedge clk);
		req_valid <= 1'b1;
		req_write <= w;
		req_addr  <= a;
		req_data  <= d;
		req_tag   <= t;
		model_request(w, a, d, t);
	endtask

	// idle cycle closes the open slot
	task automatic end_reqs();
		int n_empty;
		@(posedge clk);
		req_valid <= 1'b0;
		if (m_state[m_last] == SLOT_FILLING)
			m_state[m_last] = SLOT_FULL;
		@(posedge clk);
		@(negedge clk);
		n_empty = 0;
		for (int i = 0; i < NUM_SLOTS; i++)
			if (m_state[i] == SLOT_EMPTY)
				n_empty++;
		check_slots(n_empty > 0);             // nothing pending, one free slot will do
	endtask

	task automatic send_cmd(ddr5_cmd_e c, int s);
		logic [CA_W-1:0] p1, p2;
		logic two;
		p1  = expected_ca(c, m_addr[s], &m_mask[s], 1'b0);
		p2  = expected_ca(c, m_addr[s], &m_mask[s], 1'b1);
		two = c inside {CMD_ACT, CMD_RD, CMD_WR};
		@(posedge clk);
		cmd      <= c;
		cmd_slot <= SLOT_W'(s);
		@(posedge clk);                       // phase 1 edge
		cmd <= CMD_NONE;
		@(negedge clk);
		assert (!cs_n && ca == p1) else begin
			$display("ERROR %0t: %s phase 1 ca %h cs_n %b, expected %h", $time, c.name(),
			         ca, cs_n, p1);
			value_errs++;
		end
		@(negedge clk);
		assert (two ? (!cs_n && ca == p2) : (cs_n && ca == '0)) else begin
			$display("ERROR %0t: %s phase 2 ca %h cs_n %b, expected %h", $time, c.name(),
			         ca, cs_n, p2);
			value_errs++;
		end
	endtask

	// memory model for reads, pin check for writes
	task automatic data_phase(int s);
		logic [ROW_W-1:0] row;
		logic [BURST_LEN-1:0] mask;
		row  = m_addr[s].row;
		mask = m_mask[s];
		repeat (2) @(posedge clk);            // command edge, then phase 1
		if (m_kind[s] == REQ_READ) begin
			repeat (RD_TO_DATA - 1) @(posedge clk);
			for (int k = 0; k < BURST_LEN; k++) begin
				dq_in <= {row[11:0], BEAT_W'(k)};
				@(posedge clk);
			end
			dq_in <= '0;
		end else begin
			repeat (WR_TO_DATA - 1) @(posedge clk);
			@(negedge clk);
			assert (!dq_oe) else begin
				$display("ERROR %0t: dq_oe high before the write data phase", $time);
				value_errs++;
			end
			for (int k = 0; k < BURST_LEN; k++) begin
				@(posedge clk);
				@(negedge clk);
				assert (dq_oe && dq_out == (mask[k] ? m_data[s][k] : '0) &&
				        dm_n == (mask[k] ? '0 : '1)) else begin
					$display("ERROR %0t: write beat %0d dq %h dm_n %b oe %b", $time, k,
					         dq_out, dm_n, dq_oe);
					value_errs++;
				end
			end
			@(negedge clk);
			assert (!dq_oe) else begin
				$display("ERROR %0t: dq_oe high after 16 write beats", $time);
				value_errs++;
			end
		end
	endtask

	task automatic run_burst(int s);
		int n;
		for (int k = 0; k < BURST_LEN; k++)
			if (m_mask[s][k])
				exp_q.push_back({m_kind[s] == REQ_WRITE,
				                 m_kind[s] == REQ_WRITE ? m_data[s][k]
				                                        : {m_addr[s].row[11:0], BEAT_W'(k)},
				                 m_tag[s][k]});
		send_cmd(CMD_ACT, s);
		repeat (2) @(posedge clk);
		fork
			send_cmd(m_kind[s] == REQ_WRITE ? CMD_WR : CMD_RD, s);
			data_phase(s);
		join
		send_cmd(CMD_PRE, s);
		n = 0;
		while (slot_state[s] != SLOT_EMPTY && n < 100) begin
			@(negedge clk);
			n++;
		end
		assert (slot_state[s] == SLOT_EMPTY) else begin
			$display("slot %0d was never released after its burst", s);
			other_errs++;
		end
		repeat (2) @(negedge clk);
		assert (exp_q.size() == 0) else begin
			$display("%0d beats of slot %0d were never returned", exp_q.size(), s);
			other_errs++;
			exp_q.delete();
		end
		m_state[s] = SLOT_EMPTY;
		m_mask[s]  = '0;
	endtask

	task automatic run_full();
		for (int s = 0; s < NUM_SLOTS; s++)
			if (m_state[s] == SLOT_FULL)
				run_burst(s);
	endtask

	task automatic random_round();
		int groups, n, step;
		logic [31:0] r;
		req_addr_t a;
		logic [BEAT_W-1:0] b;
		groups = 1 + xorshift() % 2;          // at most two slots, one stays spare
		for (int g = 0; g < groups; g++) begin
			r    = xorshift();
			a    = r[29:0];
			n    = 1 + xorshift() % 4;
			step = 1 + 2 * (xorshift() % 3);   // odd step keeps beats distinct
			b    = a.column[BEAT_W-1:0];
			for (int i = 0; i < n; i++) begin
				a.column[BEAT_W-1:0] = b;
				send_req(r[31], a, xorshift() % 65536, xorshift() % 16);
				b = b + BEAT_W'(step);
			end
		end
		end_reqs();
		run_full();
	endtask

	// compares returned beats against the model
	always @(negedge clk) begin
		logic [DATA_W+TAG_W:0] e;
		if (rst_n == 1'b0 && ret_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("a beat came back that nobody asked for, tag %0d", ret_tag);
				other_errs++;
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				assert ({ret_write, ret_data, ret_tag} == e) else begin
					$display("ERROR %0t: returned %b/%h/%h, expected %b/%h/%h", $time,
					         ret_write, ret_data, ret_tag, e[DATA_W+TAG_W],
					         e[DATA_W+TAG_W-1:TAG_W], e[TAG_W-1:0]);
					value_errs++;
				end
			end
		end
	end

	initial begin
		#(NUM_TESTS * 60 * 4);
		$display("watchdog expired, the test sequence did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		req_addr_t a;
		rst_n = 1'b1;                         // reset is active high
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_data = '0;
		req_tag = '0;
		cmd = CMD_NONE;
		cmd_slot = '0;
		dq_in = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			m_state[i] = SLOT_EMPTY;
			m_mask[i]  = '0;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);
		assert (cs_n && ca == '0 && !dq_oe && dm_n == '1 && !ret_valid) else begin
			$display("ERROR %0t: pins not idle after reset", $time);
			value_errs++;
		end
		check_slots(1'b0);                    // ready only after the first update

		// three merged writes, then another row opens slot 1
		a = '{bank_group: 2'd1, bank: 2'd2, row: 16'h1a5c, column: {6'd9, 4'd3}};
		send_req(1'b1, a, 16'hbeef, 4'd1);
		a.column[3:0] = 4'd1;
		send_req(1'b1, a, 16'h0101, 4'd2);
		a.column[3:0] = 4'd7;
		send_req(1'b1, a, 16'h7e57, 4'd3);
		a.row = 16'h2b00;
		a.column[3:0] = 4'd0;
		send_req(1'b1, a, 16'h5a5a, 4'd4);
		end_reqs();
		run_full();

		// read burst with first, middle and last beat
		a = '{bank_group: 2'd3, bank: 2'd0, row: 16'hc3f1, column: {6'd33, 4'd0}};
		send_req(1'b0, a, '0, 4'd5);
		a.column[3:0] = 4'd5;
		send_req(1'b0, a, '0, 4'd6);
		a.column[3:0] = 4'd15;
		send_req(1'b0, a, '0, 4'd7);
		end_reqs();
		run_full();

		// all 16 beats in slot 0, then three more rows use up the pool
		a = '{bank_group: 2'd2, bank: 2'd1, row: 16'h0770, column: {6'd5, 4'd0}};
		for (int k = 0; k < BURST_LEN; k++) begin
			a.column[3:0] = BEAT_W'(k);
			send_req(1'b1, a, xorshift() % 65536, TAG_W'(k));
		end
		for (int i = 1; i < NUM_SLOTS; i++) begin
			a.row = a.row + 16'h0101;
			send_req(i[0], a, xorshift() % 65536, TAG_W'(i));
		end
		end_reqs();                           // no EMPTY slot left, ready drops
		run_full();

		send_cmd(CMD_REFAB, 0);
		repeat (NUM_ROUNDS) random_round();
		repeat (4) @(posedge clk);
		$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: all.f
design/burst_pkg.sv
design/ddr5_pkg.sv
design/burst_if.sv
design/burst_slots.sv
design/burst_collector.sv
design/ddr5_cmd_engine.sv
design/burst_returner.sv
design/burst_handler.sv
verif/tb_burst_handler.sv

// File: Bender.yml
package:
  name: burst_handler

sources:
  - design/burst_pkg.sv
  - design/ddr5_pkg.sv
  - design/burst_if.sv
  - design/burst_slots.sv
  - design/burst_collector.sv
  - design/ddr5_cmd_engine.sv
  - design/burst_returner.sv
  - design/burst_handler.sv
  - target: test
    files:
      - verif/tb_burst_handler.sv
